// ==== cart_pkg.sv ====
`default_nettype none

package cart_pkg;

    // ============================================================
    // Widths with a meaning
    // ============================================================
    typedef logic [7:0]  byte_t;        // Bus and memory data
    typedef logic [15:0] bus_addr_t;    // 6502 address
    typedef logic [31:0] checksum_t;
    typedef logic [15:0] sector_t;      // Card sector number

    // ============================================================
    // Address map and status codes
    // ============================================================
    localparam bus_addr_t STATUS_ADDR  = 16'h0458;  // POKEY base + 8
    localparam bus_addr_t ROM_BASE     = 16'h4000;
    localparam int        SECTOR_BYTES = 512;
    localparam byte_t     STATUS_BUSY  = 8'h00;
    localparam byte_t     STATUS_DONE  = 8'h80;

    // Bus pins after the input register
    typedef struct packed {
        bus_addr_t addr;
        byte_t     data;
        logic      rw;      // 1 = read
        logic      phi2;
        logic      halt;    // Low while DMA owns the bus
    } bus_sample_t;

    // One loader write into cartridge memory
    typedef struct packed {
        logic      en;
        bus_addr_t index;
        byte_t     data;
    } mem_wr_t;

    typedef struct packed {
        logic  strobe;      // One cycle per CPU write
        byte_t data;
    } ctrl_wr_t;

    typedef enum logic [1:0] {RD_NONE, RD_STATUS, RD_ROM} rd_sel_t;

    typedef enum logic [2:0] {
        LD_IDLE,
        LD_START,
        LD_STREAM,
        LD_NEXT,
        LD_COMPLETE
    } load_state_t;

endpackage

`default_nettype wire

// ==== bus_decode.sv ====
`default_nettype none

module bus_decode (
    input  wire logic                sys_clk,
    input  wire logic                pll_lock,
    input  wire cart_pkg::bus_addr_t a,
    input  wire cart_pkg::byte_t     d_in,
    input  wire logic                phi2,
    input  wire logic                rw,
    input  wire logic                halt,
    input  wire logic                game_loaded,
    output cart_pkg::bus_sample_t    sample,
    output cart_pkg::ctrl_wr_t       ctrl_wr,
    output cart_pkg::rd_sel_t        rd_sel,
    output logic                     drive,
    output logic                     buf_dir,
    output logic                     buf_oe
);

    logic is_rom;
    logic is_status;
    logic rd_window;
    logic rom_rd;
    logic stat_rd;
    logic ctrl_cond;
    logic ctrl_cond_q;      // Write seen on the previous cycle

    // ============================================================
    // Pin sampling
    // ============================================================
    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            sample <= '0;
        end else begin
            sample.addr <= a;
            sample.data <= d_in;
            sample.rw   <= rw;
            sample.phi2 <= phi2;
            sample.halt <= halt;
        end
    end

    // ============================================================
    // Decode of the sampled bus
    // ============================================================
    assign is_rom    = (sample.addr >= cart_pkg::ROM_BASE);     // $4000-$FFFF
    assign is_status = (sample.addr == cart_pkg::STATUS_ADDR);

    // CPU owns the bus in phi2 high, DMA whenever halt is low
    assign rd_window = (sample.phi2 && sample.halt) || !sample.halt;

    assign rom_rd  = is_rom && sample.rw && rd_window;
    assign stat_rd = is_status && sample.rw && rd_window && !game_loaded;

    // Write data is only valid while phi2 is high
    assign ctrl_cond = is_status && !sample.rw && sample.phi2;

    // ============================================================
    // Registered bus control
    // ============================================================
    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            drive       <= 1'b0;
            rd_sel      <= cart_pkg::RD_NONE;
            buf_dir     <= 1'b1;
            buf_oe      <= 1'b1;        // Buffer off
            ctrl_cond_q <= 1'b0;
            ctrl_wr     <= '0;
        end else begin
            drive   <= rom_rd || stat_rd;
            buf_dir <= sample.rw;       // 1 = towards the CPU

            // Buffer must also be open to take in a control write
            buf_oe <= !(rom_rd || stat_rd || ctrl_cond);

            if (rom_rd) begin
                rd_sel <= cart_pkg::RD_ROM;
            end else if (stat_rd) begin
                rd_sel <= cart_pkg::RD_STATUS;
            end else begin
                rd_sel <= cart_pkg::RD_NONE;
            end

            // Single strobe on the first cycle of each write
            ctrl_cond_q    <= ctrl_cond;
            ctrl_wr.strobe <= ctrl_cond && !ctrl_cond_q;
            ctrl_wr.data   <= sample.data;
        end
    end

endmodule

`default_nettype wire

// ==== image_loader.sv ====
`default_nettype none

module image_loader #(
    parameter int NUM_SECTORS  = 97,
    parameter int HEADER_BYTES = 128
) (
    input  wire logic               sys_clk,
    input  wire logic               pll_lock,
    input  wire logic               card_ready,
    output logic                    sector_rd,
    output cart_pkg::sector_t       sector_addr,
    input  wire cart_pkg::byte_t    card_byte,
    input  wire logic               card_byte_valid,
    input  wire cart_pkg::ctrl_wr_t ctrl_wr,
    output cart_pkg::mem_wr_t       mem_wr,
    output logic                    busy,
    output logic                    game_loaded,
    output cart_pkg::checksum_t     image_checksum
);

    localparam int BYTE_W = $clog2(cart_pkg::SECTOR_BYTES);
    localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(cart_pkg::SECTOR_BYTES - 1);
    localparam cart_pkg::sector_t LAST_SECTOR = cart_pkg::sector_t'(NUM_SECTORS - 1);

    cart_pkg::load_state_t state;
    cart_pkg::sector_t     sector;      // Sector being streamed
    logic [BYTE_W-1:0]     byte_cnt;    // Byte within the sector
    logic                  wr_en;
    cart_pkg::bus_addr_t   wr_index;    // Next free memory index
    cart_pkg::byte_t       wr_data;

    logic accept;
    logic keep;

    assign accept = (state == cart_pkg::LD_STREAM) && card_byte_valid;

    // Header only lives at the front of sector 0
    assign keep = (sector != '0) || (byte_cnt >= HEADER_BYTES);

    assign mem_wr = '{en: wr_en, index: wr_index, data: wr_data};

    // ============================================================
    // Loader FSM
    // ============================================================
    always_ff @(posedge sys_clk or negedge pll_lock) begin
        if (!pll_lock) begin
            state          <= cart_pkg::LD_IDLE;
            sector         <= '0;
            byte_cnt       <= '0;
            sector_rd      <= 1'b0;
            sector_addr    <= '0;
            wr_en          <= 1'b0;
            wr_index       <= '0;
            image_checksum <= '0;
            busy           <= 1'b1;     // First load starts right away
            game_loaded    <= 1'b0;
        end else begin
            sector_rd <= 1'b0;

            // Store stage, one cycle behind the accepted byte
            wr_en <= accept && keep;
            if (wr_en) begin
                wr_index       <= wr_index + 1'b1;
                image_checksum <= image_checksum + cart_pkg::checksum_t'(wr_data);
            end

            case (state)
                cart_pkg::LD_IDLE: begin
                    if (card_ready) begin
                        state <= cart_pkg::LD_START;
                    end
                end

                cart_pkg::LD_START: begin
                    sector_rd   <= 1'b1;        // Request pulse
                    sector_addr <= sector;
                    byte_cnt    <= '0;
                    state       <= cart_pkg::LD_STREAM;
                end

                cart_pkg::LD_STREAM: begin
                    if (card_byte_valid) begin
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == LAST_BYTE) begin
                            state <= cart_pkg::LD_NEXT;
                        end
                    end
                end

                cart_pkg::LD_NEXT: begin
                    if (sector == LAST_SECTOR) begin
                        busy  <= 1'b0;
                        state <= cart_pkg::LD_COMPLETE;
                    end else begin
                        sector <= sector + 1'b1;
                        state  <= cart_pkg::LD_START;
                    end
                end

                cart_pkg::LD_COMPLETE: begin
                    // Menu hand-over through the status register
                    if (ctrl_wr.strobe) begin
                        if (ctrl_wr.data[7]) begin
                            game_loaded <= 1'b1;
                        end else if (ctrl_wr.data[6] && !game_loaded) begin
                            sector         <= '0;       // Reload from the top
                            wr_index       <= '0;
                            image_checksum <= '0;
                            busy           <= 1'b1;
                            state          <= cart_pkg::LD_START;
                        end
                    end
                end

                default: state <= cart_pkg::LD_IDLE;
            endcase
        end
    end

    // Byte held for the store stage
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            wr_data <= card_byte;
        end
    end

endmodule

`default_nettype wire

// ==== cart_rom.sv ====
`default_nettype none

module cart_rom #(
    parameter int ROM_BYTES = 49152
) (
    input  wire logic                  sys_clk,
    input  wire cart_pkg::bus_sample_t sample,
    input  wire cart_pkg::rd_sel_t     rd_sel,
    input  wire logic                  busy,
    input  wire logic                  game_loaded,
    input  wire cart_pkg::mem_wr_t     mem_wr,
    output cart_pkg::byte_t            rd_data
);

    localparam int              IDX_W    = $clog2(ROM_BYTES);
    localparam cart_pkg::byte_t OPEN_BUS = 8'hFF;      // Unmapped or menu reads

    cart_pkg::byte_t     mem [ROM_BYTES];
    cart_pkg::bus_addr_t rom_index;
    logic                in_range;
    logic                wr_ok;

    assign rom_index = sample.addr - cart_pkg::ROM_BASE;
    assign in_range  = (rom_index < ROM_BYTES);
    assign wr_ok     = (mem_wr.index < ROM_BYTES);   // Drop bytes past the end

    // ============================================================
    // Cartridge memory
    // ============================================================
    always_ff @(posedge sys_clk) begin
        if (mem_wr.en && wr_ok) begin
            mem[mem_wr.index[IDX_W-1:0]] <= mem_wr.data;
        end
    end

    // ============================================================
    // Read data register
    // ============================================================
    always_ff @(posedge sys_clk) begin
        case (rd_sel)
            cart_pkg::RD_STATUS: begin
                rd_data <= busy ? cart_pkg::STATUS_BUSY : cart_pkg::STATUS_DONE;
            end

            cart_pkg::RD_ROM: begin
                // Menu still running, so the ROM region reads open bus
                if (game_loaded && in_range) begin
                    rd_data <= mem[rom_index[IDX_W-1:0]];
                end else begin
                    rd_data <= OPEN_BUS;
                end
            end

            default: rd_data <= OPEN_BUS;
        endcase
    end

endmodule

`default_nettype wire

// ==== cart_top.sv ====
`default_nettype none

module cart_top #(
    parameter int ROM_BYTES    = 49152,
    parameter int NUM_SECTORS  = 97,     // 48K image plus header
    parameter int HEADER_BYTES = 128
) (
    input  wire logic                sys_clk,
    input  wire logic                pll_lock,

    // 6502 bus
    input  wire cart_pkg::bus_addr_t a,
    inout  wire cart_pkg::byte_t     d,
    input  wire logic                phi2,
    input  wire logic                rw,
    input  wire logic                halt,

    // External data buffer
    output logic                     buf_dir,
    output logic                     buf_oe,

    // Card byte stream
    input  wire logic                card_ready,
    output logic                     sector_rd,
    output cart_pkg::sector_t        sector_addr,
    input  wire cart_pkg::byte_t     card_byte,
    input  wire logic                card_byte_valid,

    output logic                     game_loaded,
    output cart_pkg::checksum_t      image_checksum
);

    cart_pkg::bus_sample_t sample;
    cart_pkg::ctrl_wr_t    ctrl_wr;
    cart_pkg::rd_sel_t     rd_sel;
    cart_pkg::mem_wr_t     mem_wr;
    cart_pkg::byte_t       rd_data;
    logic                  drive;
    logic                  busy;

    // Only drive inside a valid read window
    assign d = drive ? rd_data : 'z;

    bus_decode u_bus_decode (
        .sys_clk     (sys_clk),
        .pll_lock    (pll_lock),
        .a           (a),
        .d_in        (d),
        .phi2        (phi2),
        .rw          (rw),
        .halt        (halt),
        .game_loaded (game_loaded),
        .sample      (sample),
        .ctrl_wr     (ctrl_wr),
        .rd_sel      (rd_sel),
        .drive       (drive),
        .buf_dir     (buf_dir),
        .buf_oe      (buf_oe)
    );

    image_loader #(
        .NUM_SECTORS  (NUM_SECTORS),
        .HEADER_BYTES (HEADER_BYTES)
    ) u_image_loader (
        .sys_clk         (sys_clk),
        .pll_lock        (pll_lock),
        .card_ready      (card_ready),
        .sector_rd       (sector_rd),
        .sector_addr     (sector_addr),
        .card_byte       (card_byte),
        .card_byte_valid (card_byte_valid),
        .ctrl_wr         (ctrl_wr),
        .mem_wr          (mem_wr),
        .busy            (busy),
        .game_loaded     (game_loaded),
        .image_checksum  (image_checksum)
    );

    cart_rom #(
        .ROM_BYTES (ROM_BYTES)
    ) u_cart_rom (
        .sys_clk     (sys_clk),
        .sample      (sample),
        .rd_sel      (rd_sel),
        .busy        (busy),
        .game_loaded (game_loaded),
        .mem_wr      (mem_wr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// ==== tb_cart_sva.sv ====
`default_nettype none

module tb_cart_sva (
    input wire logic                sys_clk,
    input wire logic                pll_lock,
    input wire cart_pkg::bus_addr_t a,
    input wire logic                phi2,
    input wire logic                rw,
    input wire logic                drive,
    input wire logic                buf_dir,
    input wire logic                buf_oe
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;       // Read by the testbench at the end

    // ============================================================
    // Buffer and drive rules
    // ============================================================
    // Buffer opens only for a driven read or a control write
    oe_when_needed: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        $past(pll_lock, 2) |->
            (!buf_oe == (drive || (!$past(rw, 2) && $past(phi2, 2)
                                   && ($past(a, 2) == cart_pkg::STATUS_ADDR)))))
    else begin
        $error("buffer enable does not match the bus access");
        fail_cnt++;
    end

    // Pin register plus control register
    dir_follows_rw: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        $past(pll_lock, 2) |-> (buf_dir == $past(rw, 2)))
    else begin
        $error("buffer direction does not follow rw");
        fail_cnt++;
    end

    no_drive_on_write: assert property (@(posedge sys_clk) disable iff (!pll_lock)
        drive |-> $past(rw, 2))
    else begin
        $error("data bus driven during a write");
        fail_cnt++;
    end

    // First two cycles out of reset
    oe_off_after_reset: assert property (@(posedge sys_clk)
        (pll_lock && !$past(pll_lock, 2)) |-> buf_oe)
    else begin
        $error("buffer enabled right after reset");
        fail_cnt++;
    end

endmodule

bind cart_top tb_cart_sva u_sva (
    .sys_clk  (sys_clk),
    .pll_lock (pll_lock),
    .a        (a),
    .phi2     (phi2),
    .rw       (rw),
    .drive    (drive),
    .buf_dir  (buf_dir),
    .buf_oe   (buf_oe)
);

`default_nettype wire

// ==== tb_cart.sv ====
`default_nettype none

module tb_cart;

    timeunit 1ns;
    timeprecision 100ps;

    // ============================================================
    // Test setup
    // ============================================================
    localparam int NUM_SECTORS = 2;
    localparam int ROM_BYTES   = 1024;
    localparam int HEADER      = 128;      // Skipped at the front of sector 0
    localparam int SECTOR_SIZE = 512;
    localparam int LOAD_BYTES  = NUM_SECTORS * SECTOR_SIZE;
    localparam int MAX_GAP     = 3;        // Idle cycles between card bytes
    localparam int LOAD_CYCLES = LOAD_BYTES * (MAX_GAP + 1) + 64;
    localparam int WATCHDOG    = 20 * 2 * LOAD_CYCLES;
    localparam int MAX_POLLS   = LOAD_CYCLES / 8 + 16;
    localparam logic [15:0] STAT_ADDR = 16'h0458;
    localparam logic [15:0] ROM_ADDR  = 16'h4000;
    localparam logic [7:0]  ST_BUSY   = 8'h00;
    localparam logic [7:0]  ST_DONE   = 8'h80;

    logic                 sys_clk;
    logic                 pll_lock;
    cart_pkg::bus_addr_t  a;
    logic                 phi2;
    logic                 rw;
    logic                 halt;
    cart_pkg::byte_t      d_drv;
    logic                 d_en;
    wire cart_pkg::byte_t d;
    logic                 buf_dir;
    logic                 buf_oe;
    logic                 card_ready;
    logic                 sector_rd;
    cart_pkg::sector_t    sector_addr;
    cart_pkg::byte_t      card_byte;
    logic                 card_byte_valid;
    logic                 game_loaded;
    cart_pkg::checksum_t  image_checksum;

    cart_pkg::byte_t   stream [2 * LOAD_BYTES];    // Card data for two loads
    cart_pkg::sector_t req_q [$];                  // Sector requests seen
    int                err_cnt   = 0;
    int                test_cnt  = 0;
    int                test_fail = 0;
    int                mark      = 0;

    assign d = d_en ? d_drv : 'z;   // CPU side of a write

    cart_top #(
        .ROM_BYTES    (ROM_BYTES),
        .NUM_SECTORS  (NUM_SECTORS),
        .HEADER_BYTES (HEADER)
    ) u_dut (
        .sys_clk         (sys_clk),
        .pll_lock        (pll_lock),
        .a               (a),
        .d               (d),
        .phi2            (phi2),
        .rw              (rw),
        .halt            (halt),
        .buf_dir         (buf_dir),
        .buf_oe          (buf_oe),
        .card_ready      (card_ready),
        .sector_rd       (sector_rd),
        .sector_addr     (sector_addr),
        .card_byte       (card_byte),
        .card_byte_valid (card_byte_valid),
        .game_loaded     (game_loaded),
        .image_checksum  (image_checksum)
    );

    initial begin : clock_gen
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge sys_clk);
        $display("Timeout after %0d cycles, the tests did not finish", WATCHDOG);
        $display("Checks failed");
        $finish;
    end

    // ============================================================
    // Card stream model
    // ============================================================
    initial begin : card_model
        int pos;
        int gap;
        pos             = 0;
        card_byte       = '0;
        card_byte_valid = 1'b0;
        forever begin
            @(negedge sys_clk);
            if (sector_rd) begin
                req_q.push_back(sector_addr);
                for (int i = 0; i < SECTOR_SIZE; i++) begin
                    card_byte_valid = 1'b0;
                    gap = int'($urandom % (MAX_GAP + 1));
                    repeat (gap) @(negedge sys_clk);
                    card_byte       = stream[pos % (2 * LOAD_BYTES)];
                    card_byte_valid = 1'b1;
                    pos++;
                    @(negedge sys_clk);
                end
                card_byte_valid = 1'b0;
            end
        end
    end

    // ============================================================
    // Expected values and checks
    // ============================================================
    function automatic cart_pkg::byte_t image_byte(input int load, input int idx);
        return stream[load * LOAD_BYTES + HEADER + idx];
    endfunction

    function automatic cart_pkg::checksum_t load_sum(input int load);
        cart_pkg::checksum_t sum;
        sum = '0;
        for (int i = HEADER; i < LOAD_BYTES; i++) begin
            sum = sum + cart_pkg::checksum_t'(stream[load * LOAD_BYTES + i]);
        end
        return sum;
    endfunction

    function automatic int total_fails();
        return err_cnt + u_dut.u_sva.fail_cnt;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act == exp) else begin
            $display("Error: %s expected %0h actual %0h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic check_true(input string name, input logic cond, input string what);
        assert (cond) else begin
            $display("%s: %s", name, what);
            err_cnt++;
        end
    endtask

    task automatic end_test(input string name);
        int fails;
        fails = total_fails() - mark;
        test_cnt++;
        if (fails == 0) begin
            $display("Test %0d %s: pass", test_cnt, name);
        end else begin
            test_fail++;
            $display("Test %0d %s: %0d wrong result(s)", test_cnt, name, fails);
        end
        mark = total_fails();
    endtask

    // ============================================================
    // Bus cycles, all driven on the falling edge
    // ============================================================
    task automatic bus_idle();
        a    = 16'h0000;
        rw   = 1'b1;
        phi2 = 1'b0;
        halt = 1'b1;
        d_en = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] addr, input logic ph, input logic hl,
                            output cart_pkg::byte_t val, output logic drv);
        @(negedge sys_clk);
        a    = addr;
        rw   = 1'b1;
        phi2 = ph;
        halt = hl;
        repeat (4) @(negedge sys_clk);      // Data valid 3 cycles after the address
        val = d;
        drv = u_dut.drive;
        repeat (2) @(negedge sys_clk);
        bus_idle();
        repeat (2) @(negedge sys_clk);
    endtask

    task automatic bus_write(input logic [15:0] addr, input cart_pkg::byte_t data);
        @(negedge sys_clk);
        a     = addr;
        rw    = 1'b0;
        phi2  = 1'b1;
        halt  = 1'b1;
        d_drv = data;
        d_en  = 1'b1;
        repeat (4) @(negedge sys_clk);
        bus_idle();
        repeat (3) @(negedge sys_clk);
    endtask

    task automatic check_read(input string name, input logic [15:0] addr, input logic ph,
                              input logic hl, input cart_pkg::byte_t exp);
        cart_pkg::byte_t val;
        logic            drv;
        bus_read(addr, ph, hl, val, drv);
        check_true(name, drv, $sformatf("read at %h was not driven", addr));
        if (drv) begin
            check_value(name, exp, val);
        end
    endtask

    task automatic check_undriven(input string name, input logic [15:0] addr,
                                  input logic ph, input logic hl);
        cart_pkg::byte_t val;
        logic            drv;
        bus_read(addr, ph, hl, val, drv);
        check_true(name, !drv, $sformatf("read at %h drove the data bus", addr));
    endtask

    // Poll the status register until the load is done
    task automatic wait_done(input string name);
        cart_pkg::byte_t val;
        logic            drv;
        int              polls;
        polls = 0;
        val   = ST_BUSY;
        while (val != ST_DONE && polls < MAX_POLLS) begin
            bus_read(STAT_ADDR, 1'b1, 1'b1, val, drv);
            polls++;
        end
        check_true(name, val == ST_DONE, "status never reported a finished load");
    endtask

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin : main
        int idx_list [6] = '{0, 1, 2, 255, 511, 895};
        void'($urandom(32'h848ad7c1));
        foreach (stream[i]) begin
            stream[i] = cart_pkg::byte_t'($urandom);
        end
        pll_lock   = 1'b0;
        card_ready = 1'b0;
        d_drv      = '0;
        bus_idle();
        repeat (2) @(negedge sys_clk);
        pll_lock = 1'b1;
        repeat (2) @(negedge sys_clk);

        check_true("busy_status", !u_dut.drive, "data bus driven after reset");
        check_read("busy_status", STAT_ADDR, 1'b1, 1'b1, ST_BUSY);
        card_ready = 1'b1;
        repeat (20) @(negedge sys_clk);
        check_read("busy_status", STAT_ADDR, 1'b1, 1'b1, ST_BUSY);
        end_test("busy_status");

        wait_done("load_done");
        check_value("load_done", load_sum(0), image_checksum);
        check_value("load_done", NUM_SECTORS, req_q.size());
        end_test("load_done");

        req_q.delete();
        bus_write(STAT_ADDR, 8'h40);
        check_read("reload", STAT_ADDR, 1'b1, 1'b1, ST_BUSY);
        wait_done("reload");
        check_value("reload", NUM_SECTORS, req_q.size());
        if (req_q.size() > 0) begin
            check_value("reload", 0, req_q[0]);     // Starts over at sector 0
        end
        check_value("reload", load_sum(1), image_checksum);
        end_test("reload");

        check_read("handover", ROM_ADDR, 1'b1, 1'b1, 8'hFF);
        bus_write(STAT_ADDR, 8'h80);
        check_true("handover", game_loaded, "game_loaded low after the hand-over write");
        foreach (idx_list[k]) begin
            check_read("handover", 16'(ROM_ADDR + idx_list[k]), 1'b1, 1'b1,
                       image_byte(1, idx_list[k]));
        end
        check_read("handover", 16'(ROM_ADDR + ROM_BYTES), 1'b1, 1'b1, 8'hFF);
        end_test("handover");

        check_read("dma_reads", 16'(ROM_ADDR + 10), 1'b0, 1'b0, image_byte(1, 10));
        check_read("dma_reads", 16'(ROM_ADDR + 600), 1'b1, 1'b0, image_byte(1, 600));
        check_undriven("dma_reads", 16'(ROM_ADDR + 10), 1'b0, 1'b1);
        end_test("dma_reads");

        $display("Summary: %0d tests, %0d failed, %0d wrong results",
                 test_cnt, test_fail, total_fails());
        if (total_fails() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
cart_pkg.sv
bus_decode.sv
image_loader.sv
cart_rom.sv
cart_top.sv
tb_cart_sva.sv
tb_cart.sv

// ==== run.sh ====
#!/bin/sh
set -e
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module tb_cart -o tb_cart
./obj_dir/tb_cart +verilator+error+limit+1000 | tee sim.log
if grep -q "^All checks passed$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
